// ==== list.f ====
common/core_pkg.sv
execute/alu.sv
execute/execute.sv
hdl/instr_decode.sv
hdl/writeback.sv
hdl/exec_core.sv
test/tb_exec_core.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_exec_core -f list.f
./obj_dir/Vtb_exec_core | tee sim.log
if grep -q "All tests passed!" sim.log; then
    echo "simulation status: pass"
else
    echo "simulation status: fail"
    exit 1
fi

// ==== test/tb_exec_core.sv ====
`timescale 1ns/10ps

module tb_exec_core import core_pkg::*; ();

    localparam logic [6:0] itype_opc = 7'b0010011;
    localparam logic [6:0] lui_opc = 7'b0110111;
    localparam logic [6:0] auipc_opc = 7'b0010111;
    localparam logic [6:0] jalr_opc = 7'b1100111;

    logic e_clk, e_rst, instr_ce, stall, flush, result_ce;
    instr_word_t instr;
    logic [31:0] pc;
    exe_result_t result;
    logic [31:0] shadow [32];
    int errs, pass_cnt, fail_cnt;

    exec_core #(.DWIDTH(32), .AWIDTH(5), .PC_WIDTH(32)) UUT (.*);

    always #5 e_clk = ~e_clk;

    function automatic instr_word_t r_type_word(input logic [6:0] f7, input logic [4:0] s2,
                                                input logic [4:0] s1, input logic [2:0] f3,
                                                input logic [4:0] rd);
        instr_word_t w;
        w.r_fmt = '{funct7: f7, rs2: s2, rs1: s1, funct3: f3, rd: rd, opcode: 7'b0110011};
        return w;
    endfunction

    function automatic instr_word_t i_type_word(input logic [11:0] imm, input logic [4:0] s1,
                                                input logic [2:0] f3, input logic [4:0] rd,
                                                input logic [6:0] opc);
        instr_word_t w;
        w.i_fmt = '{imm: imm, rs1: s1, funct3: f3, rd: rd, opcode: opc};
        return w;
    endfunction

    function automatic instr_word_t u_type_word(input logic [19:0] imm, input logic [4:0] rd,
                                                input logic [6:0] opc);
        instr_word_t w;
        w.u_fmt = '{imm_31_12: imm, rd: rd, opcode: opc};
        return w;
    endfunction

    function automatic instr_word_t j_type_word(input logic [20:0] off, input logic [4:0] rd);
        instr_word_t w;
        w.j_fmt = '{imm_20: off[20], imm_10_1: off[10:1], imm_11: off[11],
                    imm_19_12: off[19:12], rd: rd, opcode: 7'b1101111};
        return w;
    endfunction

    function automatic instr_word_t b_type_word(input logic [12:0] off, input logic [4:0] s2,
                                                input logic [4:0] s1, input logic [2:0] f3);
        instr_word_t w;
        w.b_fmt = '{imm_12: off[12], imm_10_5: off[10:5], rs2: s2, rs1: s1, funct3: f3,
                    imm_4_1: off[4:1], imm_11: off[11], opcode: 7'b1100011};
        return w;
    endfunction

    // rv32i integer semantics, alt selects sub and sra.
    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic ref_branch(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
            errs++;
        end
    endtask

    task automatic finish_test(input string name);
        if (errs == 0) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: %0d errors", name, errs);
        end
        errs = 0;
    endtask

    // issues one word and checks its single result pulse.
    // a write to x31 follows each redirect and must be killed.
    task automatic run_instr(input instr_word_t w, input logic [31:0] at_pc,
                             input logic exp_we, input logic [31:0] exp_data,
                             input logic exp_chg, input logic [31:0] exp_next);
        int cycles;
        cycles = 0;
        instr = w;
        pc = at_pc;
        instr_ce = 1'b1;
        do begin
            @(posedge e_clk);
            #1;
            instr_ce = exp_chg && (cycles == 0);
            instr = i_type_word(12'h5a5, 5'd0, 3'd0, 5'd31, itype_opc);
            pc = at_pc + 32'd4;
            cycles++;
        end while (!result_ce && cycles < 10);
        if (!result_ce) begin
            $display("timeout: no result pulse after issue at pc 0x%08h", at_pc);
            errs++;
            return;
        end
        expect_eq("result_ce latency", 32'(cycles), 32'd2);
        expect_eq("result.we", 32'(result.we), 32'(exp_we));
        expect_eq("result.change_pc", 32'(result.change_pc), 32'(exp_chg));
        if (exp_we) begin
            expect_eq("result.rd_addr", 32'(result.rd_addr), 32'(w.r_fmt.rd));
            expect_eq("result.rd_data", result.rd_data, exp_data);
            if (w.r_fmt.rd != 5'd0) begin
                shadow[w.r_fmt.rd] = exp_data;
            end
        end
        if (exp_chg) begin
            expect_eq("result.next_pc", result.next_pc, exp_next);
        end
        @(posedge e_clk);
        #1;
        expect_eq("result_ce", 32'(result_ce), 32'd0);
    endtask

    task automatic alu_op(input logic reg_op, input logic [2:0] f3, input logic alt,
                          input logic [4:0] rd, input logic [4:0] s1, input logic [4:0] s2,
                          input logic [11:0] imm);
        logic alt_eff;
        logic [11:0] imm_f;
        logic [31:0] b;
        instr_word_t w;
        alt_eff = alt && (f3 == 3'd5 || (reg_op && f3 == 3'd0));
        imm_f = (f3 == 3'd1 || f3 == 3'd5) ? {1'b0, alt_eff, 5'b0, imm[4:0]} : imm;
        if (reg_op) begin
            w = r_type_word({1'b0, alt_eff, 5'b0}, s2, s1, f3, rd);
            b = shadow[s2];
        end else begin
            w = i_type_word(imm_f, s1, f3, rd, itype_opc);
            b = {{20{imm_f[11]}}, imm_f};
        end
        run_instr(w, 32'($urandom) & 32'hffff_fffc, 1'b1, ref_alu(f3, alt_eff, shadow[s1], b),
                  1'b0, 32'd0);
    endtask

    // lui then addi, with the upper part rounded for the signed low half.
    task automatic load_reg(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] hi;
        hi = (v + 32'h800) & 32'hffff_f000;
        run_instr(u_type_word(hi[31:12], rd, lui_opc), 32'h200, 1'b1, hi, 1'b0, 32'd0);
        alu_op(1'b0, 3'd0, 1'b0, rd, rd, 5'd0, v[11:0]);
    endtask

    task automatic jump_test();
        logic [31:0] p, u, r, off, next;
        logic [4:0] rd, s1;
        for (int i = 0; i < 12; i++) begin
            p = 32'($urandom) & 32'hffff_fffc;
            u = 32'($urandom);
            r = 32'($urandom);
            rd = 5'($urandom_range(30, 1));
            s1 = 5'($urandom_range(30, 1));
            run_instr(u_type_word(u[19:0], rd, lui_opc), p, 1'b1, {u[19:0], 12'b0},
                      1'b0, 32'd0);
            run_instr(u_type_word(u[19:0], rd, auipc_opc), p, 1'b1, p + {u[19:0], 12'b0},
                      1'b0, 32'd0);
            off = {{11{r[20]}}, r[20:1], 1'b0};
            run_instr(j_type_word(off[20:0], rd), p, 1'b1, p + 32'd4, 1'b1, p + off);
            next = (shadow[s1] + {{20{r[31]}}, r[31:20]}) & 32'hffff_fffe;
            run_instr(i_type_word(r[31:20], s1, 3'd0, rd, jalr_opc), p, 1'b1, p + 32'd4,
                      1'b1, next);
        end
        alu_op(1'b0, 3'd0, 1'b0, 5'd0, 5'd31, 5'd0, 12'd0);
    endtask

    task automatic branch_test();
        logic [31:0] p, r, off;
        load_reg(5'd1, 32'h8000_0000);
        load_reg(5'd2, 32'h7fff_ffff);
        load_reg(5'd3, 32'hffff_ffff);
        load_reg(5'd4, 32'h0000_0001);
        for (int c = 0; c < 8; c++) begin
            if (c == 2 || c == 3) continue;
            for (int i = 1; i <= 4; i++) begin
                for (int j = 1; j <= 4; j++) begin
                    p = 32'($urandom) & 32'hffff_fffc;
                    r = 32'($urandom);
                    off = {{19{r[12]}}, r[12:1], 1'b0};
                    run_instr(b_type_word(off[12:0], 5'(j), 5'(i), 3'(c)), p, 1'b0, 32'd0,
                              ref_branch(3'(c), shadow[i], shadow[j]), p + off);
                end
            end
        end
    endtask

    // the word offered during the stall targets x30 and must be dropped.
    task automatic stall_test();
        int n;
        instr = i_type_word(12'h123, 5'd0, 3'd0, 5'd5, itype_opc);
        pc = 32'h100;
        instr_ce = 1'b1;
        n = 0;
        do begin
            @(posedge e_clk);
            #1;
            instr_ce = 1'b0;
            n++;
        end while (!result_ce && n < 10);
        if (!result_ce) begin
            $display("timeout: the instruction before the stall never produced a result");
            errs++;
        end
        stall = 1'b1;
        instr = i_type_word(12'h3c3, 5'd0, 3'd0, 5'd30, itype_opc);
        instr_ce = 1'b1;
        repeat (4) begin
            @(posedge e_clk);
            #1;
            expect_eq("result_ce", 32'(result_ce), 32'd1);
            expect_eq("result.rd_data", result.rd_data, 32'h123);
        end
        stall = 1'b0;
        instr_ce = 1'b0;
        @(posedge e_clk);
        #1;
        expect_eq("result_ce", 32'(result_ce), 32'd0);
        shadow[5] = 32'h123;
    endtask

    // flush spans the edge that takes the first word into execute and the next one.
    task automatic flush_test();
        instr = i_type_word(12'h2a1, 5'd0, 3'd0, 5'd28, itype_opc);
        pc = 32'h300;
        instr_ce = 1'b1;
        @(posedge e_clk);
        #1;
        instr = i_type_word(12'h2b2, 5'd0, 3'd0, 5'd29, itype_opc);
        flush = 1'b1;
        for (int k = 0; k < 3; k++) begin
            @(posedge e_clk);
            #1;
            instr_ce = 1'b0;
            flush = (k == 0);
            expect_eq("result_ce", 32'(result_ce), 32'd0);
        end
    endtask

    initial begin
        void'($urandom(99541));
        e_clk = 1'b0;
        e_rst = 1'b0;
        instr = '0;
        pc = '0;
        instr_ce = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        errs = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        for (int r = 0; r < 32; r++) begin
            shadow[r] = '0;
        end
        repeat (4) @(posedge e_clk);
        #1;
        e_rst = 1'b1;

        expect_eq("result_ce", 32'(result_ce), 32'd0);
        expect_eq("result.we", 32'(result.we), 32'd0);
        expect_eq("result.change_pc", 32'(result.change_pc), 32'd0);
        for (int r = 0; r < 32; r++) begin
            alu_op(1'b0, 3'd0, 1'b0, 5'd0, 5'(r), 5'd0, 12'(r * 7 + 1));
        end
        finish_test("reset");

        load_reg(5'd1, 32'h8000_0000);
        load_reg(5'd2, 32'h7fff_ffff);
        load_reg(5'd3, 32'hffff_ffff);
        load_reg(5'd4, 32'h0000_0001);
        for (int i = 1; i <= 4; i++) begin
            for (int j = 1; j <= 4; j++) begin
                alu_op(1'b1, 3'd2, 1'b0, 5'd5, 5'(i), 5'(j), 12'd0);
                alu_op(1'b1, 3'd3, 1'b0, 5'd6, 5'(i), 5'(j), 12'd0);
            end
        end
        for (int s = 0; s < 32; s++) begin
            alu_op(1'b0, 3'd5, 1'b1, 5'd7, 5'd1, 5'd0, 12'(s));
            alu_op(1'b0, 3'd5, 1'b0, 5'd8, 5'd1, 5'd0, 12'(s));
            alu_op(1'b0, 3'd1, 1'b0, 5'd9, 5'd3, 5'd0, 12'(s));
        end
        for (int i = 0; i < 300; i++) begin
            alu_op(1'($urandom), 3'($urandom), 1'($urandom), 5'($urandom), 5'($urandom),
                   5'($urandom), 12'($urandom));
        end
        finish_test("alu");

        jump_test();
        finish_test("jumps");
        branch_test();
        finish_test("branches");

        stall_test();
        flush_test();
        alu_op(1'b0, 3'd0, 1'b0, 5'd0, 5'd5, 5'd0, 12'd0);
        alu_op(1'b0, 3'd0, 1'b0, 5'd0, 5'd30, 5'd0, 12'd0);
        alu_op(1'b0, 3'd0, 1'b0, 5'd0, 5'd28, 5'd0, 12'd0);
        alu_op(1'b0, 3'd0, 1'b0, 5'd0, 5'd29, 5'd0, 12'd0);
        finish_test("stall and flush");

        $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== hdl/exec_core.sv ====
`timescale 1ns/10ps

module exec_core import core_pkg::*; #(
    parameter int DWIDTH = 32,
    parameter int AWIDTH = 5,
    parameter int PC_WIDTH = 32
) (
    input  logic                e_clk,
    input  logic                e_rst,
    input  instr_word_t         instr,
    input  logic [PC_WIDTH-1:0] pc,
    input  logic                instr_ce,
    input  logic                stall,
    input  logic                flush,
    output exe_result_t         result,
    output logic                result_ce
);

    logic [AWIDTH-1:0] rs1_addr, rs2_addr;
    logic [DWIDTH-1:0] rs1_data, rs2_data;
    dec_bundle_t dec;
    logic dec_ce;
    logic [DWIDTH-1:0] alu_a, alu_b, alu_result;
    logic [alu_width-1:0] alu_code;
    logic dec_flush;

    // a taken redirect drops the younger instruction still in decode.
    assign dec_flush = flush || (result_ce && result.change_pc);

    instr_decode #(.DWIDTH(DWIDTH), .AWIDTH(AWIDTH), .PC_WIDTH(PC_WIDTH)) u_decode (
        .flush(dec_flush),
        .*
    );

    execute #(.DWIDTH(DWIDTH), .AWIDTH(AWIDTH), .PC_WIDTH(PC_WIDTH)) u_execute (
        .*
    );

    alu #(.DWIDTH(DWIDTH)) u_alu (
        .*
    );

    writeback #(.DWIDTH(DWIDTH), .AWIDTH(AWIDTH)) u_writeback (
        .*
    );

endmodule

// ==== hdl/writeback.sv ====
`timescale 1ns/10ps

module writeback import core_pkg::*; #(
    parameter int DWIDTH = 32,
    parameter int AWIDTH = 5
) (
    input  logic              e_clk,
    input  logic              e_rst,
    input  exe_result_t       result,
    input  logic              result_ce,
    input  logic              stall,
    input  logic [AWIDTH-1:0] rs1_addr,
    input  logic [AWIDTH-1:0] rs2_addr,
    output logic [DWIDTH-1:0] rs1_data,
    output logic [DWIDTH-1:0] rs2_data
);

    localparam int depth = 2 ** AWIDTH;

    logic [DWIDTH-1:0] regs [depth];
    logic written;
    logic wr_en;

    // a result held through a stall is written on the first edge only.
    assign wr_en = result_ce && result.we && (result.rd_addr != '0) && !written;

    always_ff @(posedge e_clk, negedge e_rst) begin
        if (!e_rst) begin
            written <= 1'b0;
            for (int i = 0; i < depth; i++) begin
                regs[i] <= '0;
            end
        end else begin
            written <= stall && (written || result_ce);
            if (wr_en) begin
                regs[result.rd_addr] <= result.rd_data;
            end
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== hdl/instr_decode.sv ====
`timescale 1ns/10ps

module instr_decode import core_pkg::*; #(
    parameter int DWIDTH = 32,
    parameter int AWIDTH = 5,
    parameter int PC_WIDTH = 32
) (
    input  logic                e_clk,
    input  logic                e_rst,
    input  instr_word_t         instr,
    input  logic [PC_WIDTH-1:0] pc,
    input  logic                instr_ce,
    input  logic                stall,
    input  logic                flush,
    output logic [AWIDTH-1:0]   rs1_addr,
    output logic [AWIDTH-1:0]   rs2_addr,
    input  logic [DWIDTH-1:0]   rs1_data,
    input  logic [DWIDTH-1:0]   rs2_data,
    output dec_bundle_t         dec,
    output logic                dec_ce
);

    localparam logic [6:0] opc_rtype = 7'b0110011;
    localparam logic [6:0] opc_itype = 7'b0010011;
    localparam logic [6:0] opc_load = 7'b0000011;
    localparam logic [6:0] opc_store = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal = 7'b1101111;
    localparam logic [6:0] opc_jalr = 7'b1100111;
    localparam logic [6:0] opc_lui = 7'b0110111;
    localparam logic [6:0] opc_auipc = 7'b0010111;
    localparam logic [6:0] opc_system = 7'b1110011;
    localparam logic [6:0] opc_fence = 7'b0001111;

    logic [opcode_width-1:0] op_class;
    logic [alu_width-1:0] alu_code;
    logic [DWIDTH-1:0] imm, imm_i, imm_s, imm_b, imm_u, imm_j;
    logic dec_ce_q;

    // alt selects sub (register form only) and sra.
    function automatic logic [alu_width-1:0] arith_code(input logic [2:0] f3,
                                                       input logic alt,
                                                       input logic reg_op);
        logic [alu_width-1:0] code;
        code = '0;
        case (f3)
            3'd0: code[(alt && reg_op) ? alu_sub : alu_add] = 1'b1;
            3'd1: code[alu_sll] = 1'b1;
            3'd2: code[alu_slt] = 1'b1;
            3'd3: code[alu_sltu] = 1'b1;
            3'd4: code[alu_xor] = 1'b1;
            3'd5: code[alt ? alu_sra : alu_srl] = 1'b1;
            3'd6: code[alu_or] = 1'b1;
            default: code[alu_and] = 1'b1;
        endcase
        return code;
    endfunction

    assign rs1_addr = instr.r_fmt.rs1;
    assign rs2_addr = instr.r_fmt.rs2;

    assign imm_i = {{(DWIDTH-12){instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
    assign imm_s = {{(DWIDTH-12){instr.s_fmt.imm_11_5[6]}}, instr.s_fmt.imm_11_5,
                    instr.s_fmt.imm_4_0};
    assign imm_b = {{(DWIDTH-13){instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                    instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
    assign imm_u = DWIDTH'({instr.u_fmt.imm_31_12, 12'b0});
    assign imm_j = {{(DWIDTH-21){instr.j_fmt.imm_20}}, instr.j_fmt.imm_20,
                    instr.j_fmt.imm_19_12, instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};

    // load, store, system and fence keep a zero alu code and act as nops.
    always_comb begin
        op_class = '0;
        alu_code = '0;
        imm = '0;
        case (instr.r_fmt.opcode)
            opc_rtype: begin
                op_class[op_rtype] = 1'b1;
                alu_code = arith_code(instr.r_fmt.funct3, instr.r_fmt.funct7[5], 1'b1);
            end
            opc_itype: begin
                op_class[op_itype] = 1'b1;
                alu_code = arith_code(instr.i_fmt.funct3, instr.r_fmt.funct7[5], 1'b0);
                imm = imm_i;
            end
            opc_branch: begin
                op_class[op_branch] = 1'b1;
                imm = imm_b;
                case (instr.b_fmt.funct3)
                    3'd0: alu_code[alu_eq] = 1'b1;
                    3'd1: alu_code[alu_neq] = 1'b1;
                    3'd4: alu_code[alu_slt] = 1'b1;
                    3'd5: alu_code[alu_ge] = 1'b1;
                    3'd6: alu_code[alu_sltu] = 1'b1;
                    3'd7: alu_code[alu_geu] = 1'b1;
                    default: alu_code = '0;
                endcase
            end
            opc_jal: begin
                op_class[op_jal] = 1'b1;
                alu_code[alu_add] = 1'b1;
                imm = imm_j;
            end
            opc_jalr: begin
                op_class[op_jalr] = 1'b1;
                alu_code[alu_add] = 1'b1;
                imm = imm_i;
            end
            opc_lui: begin
                op_class[op_lui] = 1'b1;
                alu_code[alu_add] = 1'b1;
                imm = imm_u;
            end
            opc_auipc: begin
                op_class[op_auipc] = 1'b1;
                alu_code[alu_add] = 1'b1;
                imm = imm_u;
            end
            opc_load: begin
                op_class[op_load_word] = 1'b1;
                imm = imm_i;
            end
            opc_store: begin
                op_class[op_store_word] = 1'b1;
                imm = imm_s;
            end
            opc_system: op_class[op_system] = 1'b1;
            opc_fence: op_class[op_fence] = 1'b1;
            default: op_class = '0;
        endcase
    end

    always_ff @(posedge e_clk, negedge e_rst) begin
        if (!e_rst) begin
            dec_ce_q <= 1'b0;
        end else if (!stall) begin
            dec_ce_q <= instr_ce;
        end
    end

    always_ff @(posedge e_clk) begin
        if (instr_ce && !stall) begin
            dec.alu <= alu_code;
            dec.opcode <= op_class;
            dec.funct3 <= instr.r_fmt.funct3;
            dec.rd_addr <= instr.r_fmt.rd;
            dec.rs1 <= rs1_data;
            dec.rs2 <= rs2_data;
            dec.imm <= imm;
            dec.pc <= pc;
        end
    end

    // a flush kills the held instruction before execute can take it.
    // the word sampled on the same edge still loads.
    assign dec_ce = dec_ce_q && !flush;

endmodule

// ==== execute/execute.sv ====
`timescale 1ns/10ps

module execute import core_pkg::*; #(
    parameter int DWIDTH = 32,
    parameter int AWIDTH = 5,
    parameter int PC_WIDTH = 32
) (
    input  logic                 e_clk,
    input  logic                 e_rst,
    input  dec_bundle_t          dec,
    input  logic                 dec_ce,
    input  logic                 stall,
    input  logic                 flush,
    input  logic [DWIDTH-1:0]    alu_result,
    output logic [DWIDTH-1:0]    alu_a,
    output logic [DWIDTH-1:0]    alu_b,
    output logic [alu_width-1:0] alu_code,
    output exe_result_t          result,
    output logic                 result_ce
);

    logic is_rtype, is_itype, is_branch, is_jal, is_jalr, is_lui, is_auipc;
    logic taken;
    logic [PC_WIDTH-1:0] link_pc, branch_target, jalr_target;
    logic res_we, res_change_pc;
    logic [AWIDTH-1:0] res_rd_addr;
    logic [DWIDTH-1:0] res_rd_data;
    logic [PC_WIDTH-1:0] res_next_pc;

    assign is_rtype = dec.opcode[op_rtype];
    assign is_itype = dec.opcode[op_itype];
    assign is_branch = dec.opcode[op_branch];
    assign is_jal = dec.opcode[op_jal];
    assign is_jalr = dec.opcode[op_jalr];
    assign is_lui = dec.opcode[op_lui];
    assign is_auipc = dec.opcode[op_auipc];

    assign alu_code = dec.alu;

    always_comb begin
        if (is_lui) begin
            alu_a = '0;
        end else if (is_jal || is_auipc) begin
            alu_a = DWIDTH'(dec.pc);
        end else begin
            alu_a = dec.rs1;
        end
    end

    assign alu_b = (is_rtype || is_branch) ? dec.rs2 : dec.imm;

    assign link_pc = PC_WIDTH'(dec.pc) + PC_WIDTH'(4);
    assign branch_target = PC_WIDTH'(dec.pc) + PC_WIDTH'(dec.imm);
    assign jalr_target = PC_WIDTH'(dec.rs1 + dec.imm) & ~PC_WIDTH'(1);

    // branch compares leave their outcome in bit 0.
    assign taken = is_jal || is_jalr || (is_branch && alu_result[0]);

    always_ff @(posedge e_clk, negedge e_rst) begin
        if (!e_rst) begin
            result_ce <= 1'b0;
            res_we <= 1'b0;
            res_change_pc <= 1'b0;
        end else if (!stall) begin
            result_ce <= dec_ce && !flush;
            if (dec_ce) begin
                res_we <= is_rtype || is_itype || is_jal || is_jalr || is_lui || is_auipc;
                res_change_pc <= taken;
            end
        end
    end

    always_ff @(posedge e_clk) begin
        if (dec_ce && !stall) begin
            res_rd_addr <= dec.rd_addr;
            res_rd_data <= (is_jal || is_jalr) ? DWIDTH'(link_pc) : alu_result;
            res_next_pc <= is_jalr ? jalr_target : branch_target;
        end
    end

    assign result = '{
        we: res_we,
        rd_addr: res_rd_addr,
        rd_data: res_rd_data,
        change_pc: res_change_pc,
        next_pc: res_next_pc
    };

endmodule

// ==== execute/alu.sv ====
`timescale 1ns/10ps

module alu import core_pkg::*; #(
    parameter int DWIDTH = 32
) (
    input  logic [DWIDTH-1:0]    alu_a,
    input  logic [DWIDTH-1:0]    alu_b,
    input  logic [alu_width-1:0] alu_code,
    output logic [DWIDTH-1:0]    alu_result
);

    logic [4:0] shamt;
    logic is_eq, is_lt, is_ltu;

    function automatic logic [DWIDTH-1:0] flag_word(input logic flag);
        return {{(DWIDTH-1){1'b0}}, flag};
    endfunction

    assign shamt = alu_b[4:0];
    assign is_eq = (alu_a == alu_b);
    assign is_lt = ($signed(alu_a) < $signed(alu_b));
    assign is_ltu = (alu_a < alu_b);

    // exactly one bit is set.
    // an empty code gives zero.
    always_comb begin
        case (1'b1)
            alu_code[alu_add]: alu_result = alu_a + alu_b;
            alu_code[alu_sub]: alu_result = alu_a - alu_b;
            alu_code[alu_slt]: alu_result = flag_word(is_lt);
            alu_code[alu_sltu]: alu_result = flag_word(is_ltu);
            alu_code[alu_xor]: alu_result = alu_a ^ alu_b;
            alu_code[alu_or]: alu_result = alu_a | alu_b;
            alu_code[alu_and]: alu_result = alu_a & alu_b;
            alu_code[alu_sll]: alu_result = alu_a << shamt;
            alu_code[alu_srl]: alu_result = alu_a >> shamt;
            alu_code[alu_sra]: alu_result = DWIDTH'($signed(alu_a) >>> shamt);
            alu_code[alu_eq]: alu_result = flag_word(is_eq);
            alu_code[alu_neq]: alu_result = flag_word(!is_eq);
            alu_code[alu_ge]: alu_result = flag_word(!is_lt);
            alu_code[alu_geu]: alu_result = flag_word(!is_ltu);
            default: alu_result = '0;
        endcase
    end

endmodule

// ==== common/core_pkg.sv ====
package core_pkg;

    localparam int def_dwidth = 32;
    localparam int def_awidth = 5;
    localparam int def_pc_width = 32;

    localparam int alu_width = 14;
    localparam int opcode_width = 11;

    // bit positions in the one-hot alu code.
    localparam int alu_add = 0;
    localparam int alu_sub = 1;
    localparam int alu_slt = 2;
    localparam int alu_sltu = 3;
    localparam int alu_xor = 4;
    localparam int alu_or = 5;
    localparam int alu_and = 6;
    localparam int alu_sll = 7;
    localparam int alu_srl = 8;
    localparam int alu_sra = 9;
    localparam int alu_eq = 10;
    localparam int alu_neq = 11;
    localparam int alu_ge = 12;
    localparam int alu_geu = 13;

    // bit positions in the one-hot opcode class.
    localparam int op_rtype = 0;
    localparam int op_itype = 1;
    localparam int op_load_word = 2;
    localparam int op_store_word = 3;
    localparam int op_branch = 4;
    localparam int op_jal = 5;
    localparam int op_jalr = 6;
    localparam int op_lui = 7;
    localparam int op_auipc = 8;
    localparam int op_system = 9;
    localparam int op_fence = 10;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2, rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2, rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2, rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } u_fmt_t;

    typedef struct packed {
        logic imm_20;
        logic [9:0] imm_10_1;
        logic imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, seen through each encoding format.
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_word_t;

    // an instruction ready to execute.
    typedef struct packed {
        logic [alu_width-1:0] alu;
        logic [opcode_width-1:0] opcode;
        logic [2:0] funct3;
        logic [def_awidth-1:0] rd_addr;
        logic [def_dwidth-1:0] rs1, rs2, imm;
        logic [def_pc_width-1:0] pc;
    } dec_bundle_t;

    typedef struct packed {
        logic we;
        logic [def_awidth-1:0] rd_addr;
        logic [def_dwidth-1:0] rd_data;
        logic change_pc;
        logic [def_pc_width-1:0] next_pc;
    } exe_result_t;

endpackage
